// File: tb.f
+incdir+include
hdl/dcache_pkg.sv
hdl/cache_store.sv
hdl/plru_tree.sv
hdl/d_cache.sv
dv/mem_model.sv
dv/tb_d_cache.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps --top-module tb_d_cache -f tb.f -Mdir obj_dir
	out=$$(./obj_dir/Vtb_d_cache); echo "$$out"; echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir

// File: dv/tb_d_cache.sv
`timescale 1ns/100ps
`include "dcache_defs.svh"

module tb_d_cache;

    localparam logic [31:0] SEED = 32'h7085_0abc;
    localparam int RAND_OPS        = 300;
    localparam int OP_BUDGET       = RAND_OPS + 40;  // directed tests on top
    localparam int MAX_MISS_CYCLES = 40;             // writeback plus refill at max delays
    localparam int CLK_NS          = 4;
    localparam int WATCHDOG_NS     = (8 + OP_BUDGET * MAX_MISS_CYCLES * 4) * CLK_NS;
    localparam logic [31:0] PART_BASE = 32'h1000_0100;
    localparam logic [`DC_INDEX_WIDTH-1:0] EVICT_SET     = 10'h05a;
    localparam logic [`DC_INDEX_WIDTH-1:0] RAND_SET_BASE = 10'h120;
    localparam int EVICT_ORDER [15] = '{0, 1, 2, 3, 4, 5, 0, 1, 2, 3, 4, 5, 2, 0, 3};

    logic clk;
    logic rst;
    logic data_req;
    logic data_wr;
    dcache_pkg::dc_size_e data_size;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [31:0] data_rdata;
    logic data_addr_ok;
    logic data_data_ok;
    logic mem_req;
    logic mem_wr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic mem_addr_ok;
    logic mem_data_ok;
    int addr_delay;
    int data_delay;
    int mem_reads;
    int mem_writes;
    logic [31:0] last_rd_addr;
    logic [31:0] last_wr_addr;
    logic [31:0] last_wr_data;

    logic [31:0] lfsr_state;
    int checks;
    int errors;
    int tests;
    int test_err_base;
    string cur_test;
    logic [31:0] exp_q [$];  // expected read data in issue order

    // reference state: flat memory plus a shadow of tags and trees
    logic [31:0]              ref_mem [logic [29:0]];
    logic [`DC_TAG_WIDTH-1:0] m_tag   [`DC_SETS][`DC_WAYS];
    logic [`DC_WAYS-1:0]      m_valid [`DC_SETS];
    logic [`DC_WAYS-1:0]      m_dirty [`DC_SETS];
    logic [2:0]               m_tree  [`DC_SETS];

    d_cache dut (.*);

    mem_model mem (
        .clk(clk), .rst(rst), .mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok), .addr_delay(addr_delay), .data_delay(data_delay),
        .reads(mem_reads), .writes(mem_writes), .last_rd_addr(last_rd_addr),
        .last_wr_addr(last_wr_addr), .last_wr_data(last_wr_data)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    // same hash the memory model starts from
    function automatic logic [31:0] mem_init_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h6d2b_79f5;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        return ref_mem.exists(addr[31:2]) ? ref_mem[addr[31:2]] : mem_init_word(addr);
    endfunction

    function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] wdata,
                                               input dcache_pkg::dc_size_e size,
                                               input logic [1:0] off);
        logic [31:0] mask;
        case (size)
            dcache_pkg::SIZE_BYTE: mask = 32'h0000_00ff << (8 * off);
            dcache_pkg::SIZE_HALF: mask = off[1] ? 32'hffff_0000 : 32'h0000_ffff;
            default:               mask = 32'hffff_ffff;
        endcase
        return (old & ~mask) | (wdata & mask);
    endfunction

    // root picks the half, then the half's own bit picks the way
    function automatic logic [1:0] plru_victim(input logic [2:0] tree);
        return tree[2] ? {1'b1, tree[0]} : {1'b0, tree[1]};
    endfunction

    function automatic logic [2:0] plru_touch(input logic [2:0] tree, input logic [1:0] way);
        logic [2:0] t;
        t = tree;
        t[2] = ~way[1];
        if (way[1]) begin
            t[0] = ~way[0];
        end else begin
            t[1] = ~way[0];
        end
        return t;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_err_base = errors;
    endtask

    task automatic report_test();
        tests++;
        $display("test %-18s %s (%0d errors)", cur_test,
                 (errors == test_err_base) ? "ok" : "failing", errors - test_err_base);
    endtask

    // one core access, checked against the shadow model
    task automatic access(input logic wr, input dcache_pkg::dc_size_e size,
                          input logic [31:0] addr, input logic [31:0] wdata);
        logic [`DC_INDEX_WIDTH-1:0] idx;
        logic [`DC_TAG_WIDTH-1:0]   tg;
        logic [1:0]  way;
        logic [31:0] wb_addr;
        logic [31:0] wb_data;
        int exp_rd;
        int exp_wb;
        int rd0;
        int wr0;
        int cycles;
        int aok_cycles;
        int aok_done;
        idx = addr[`DC_INDEX_WIDTH+`DC_OFFSET_WIDTH-1:`DC_OFFSET_WIDTH];
        tg  = addr[31:`DC_INDEX_WIDTH+`DC_OFFSET_WIDTH];
        exp_rd = 1;
        exp_wb = 0;
        way = 2'd0;
        wb_addr = '0;
        wb_data = '0;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tg) begin
                exp_rd = 0;
                way = 2'(w);
            end
        end
        if (exp_rd == 1) begin
            way = plru_victim(m_tree[idx]);
            if (m_valid[idx][way] && m_dirty[idx][way]) begin
                exp_wb  = 1;
                wb_addr = {m_tag[idx][way], idx, 2'b00};
                wb_data = ref_read(wb_addr);
            end
            m_valid[idx][way] = 1'b1;
            m_dirty[idx][way] = 1'b0;
            m_tag[idx][way]   = tg;
        end
        m_tree[idx] = plru_touch(m_tree[idx], way);
        if (wr) begin
            ref_mem[addr[31:2]] = merge_word(ref_read(addr), wdata, size, addr[1:0]);
            m_dirty[idx][way] = 1'b1;
        end else begin
            exp_q.push_back(ref_read(addr));
        end

        rd0 = mem_reads;
        wr0 = mem_writes;
        @(negedge clk);
        addr_delay = int'(rand_bits(2));
        data_delay = int'(rand_bits(3));
        data_req   = 1'b1;
        data_wr    = wr;
        data_size  = size;
        data_addr  = addr;
        data_wdata = wdata;
        cycles = 0;
        aok_cycles = 0;
        aok_done = 0;
        do begin
            @(posedge clk);
            cycles++;
            aok_done = data_addr_ok ? 1 : 0;
            if (data_addr_ok) begin
                aok_cycles++;
            end
        end while (!data_data_ok);
        @(negedge clk);
        data_req = 1'b0;

        compare("mem read count", mem_reads - rd0, exp_rd);
        compare("mem write count", mem_writes - wr0, exp_wb);
        // request accepted once, in the cycle it completes
        compare("data_addr_ok", aok_done, 1);
        compare("data_addr_ok cycles", aok_cycles, 1);
        if (exp_rd == 1) begin
            compare("mem_addr on refill", last_rd_addr, {addr[31:2], 2'b00});
        end else begin
            compare("data_data_ok cycles", cycles, 1);  // hit answers at once
        end
        if (exp_wb == 1) begin
            compare("mem_addr on writeback", last_wr_addr, wb_addr);
            compare("mem_wdata", last_wr_data, wb_data);
        end
    endtask

    // read data checked on the edge that completes the read
    always @(posedge clk) begin
        if (!rst && data_req && data_data_ok && !data_wr) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("a read completed with no read outstanding");
            end else begin
                compare("data_rdata", data_rdata, exp_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: test '%s' hung waiting for data_data_ok", cur_test);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [1:0]  off;
        logic [`DC_INDEX_WIDTH-1:0] idx;
        logic [`DC_TAG_WIDTH-1:0]   tg;
        dcache_pkg::dc_size_e       size;
        clk = 1'b0;
        rst = 1'b1;
        data_req = 1'b0;
        data_wr = 1'b0;
        data_size = dcache_pkg::SIZE_WORD;
        data_addr = '0;
        data_wdata = '0;
        addr_delay = 0;
        data_delay = 0;
        lfsr_state = SEED;
        checks = 0;
        errors = 0;
        tests = 0;
        cur_test = "reset";
        for (int s = 0; s < `DC_SETS; s++) begin
            m_valid[s] = '0;
            m_dirty[s] = '0;
            m_tree[s]  = 3'b000;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test("cold read miss");
        access(1'b0, dcache_pkg::SIZE_WORD, 32'h0040_1a3c, '0);
        report_test();

        begin_test("read hit");
        access(1'b0, dcache_pkg::SIZE_WORD, 32'h0040_1a3c, '0);
        access(1'b0, dcache_pkg::SIZE_WORD, 32'h0040_1a3c, '0);
        report_test();

        begin_test("partial stores");
        for (int o = 0; o < 4; o++) begin
            access(1'b1, dcache_pkg::SIZE_BYTE, PART_BASE + o, rand_bits(32));
            access(1'b0, dcache_pkg::SIZE_WORD, PART_BASE, '0);
        end
        for (int o = 0; o < 4; o += 2) begin
            access(1'b1, dcache_pkg::SIZE_HALF, PART_BASE + o, rand_bits(32));
            access(1'b0, dcache_pkg::SIZE_WORD, PART_BASE, '0);
        end
        access(1'b1, dcache_pkg::SIZE_WORD, PART_BASE, rand_bits(32));
        access(1'b0, dcache_pkg::SIZE_WORD, PART_BASE, '0);
        report_test();

        begin_test("eviction");
        for (int i = 0; i < 15; i++) begin
            tg = {16'h3c00, 4'(EVICT_ORDER[i])};  // six tags on one set
            access((i % 3) != 1, dcache_pkg::SIZE_WORD, {tg, EVICT_SET, 2'b00}, rand_bits(32));
        end
        report_test();

        begin_test("random mix");
        for (int i = 0; i < RAND_OPS; i++) begin
            r = rand_bits(2);
            size = (r[1:0] == 2'd3) ? dcache_pkg::SIZE_WORD : dcache_pkg::dc_size_e'(r[1:0]);
            r = rand_bits(2);
            case (size)
                dcache_pkg::SIZE_BYTE: off = r[1:0];
                dcache_pkg::SIZE_HALF: off = {r[1], 1'b0};
                default:               off = 2'b00;
            endcase
            r = rand_bits(2);
            idx = RAND_SET_BASE + 10'(r[1:0]);  // four sets
            r = rand_bits(3);
            tg = {17'h1_874a, r[2:0]};     // eight tags per set
            r = rand_bits(1);
            access(r[0], size, {tg, idx, off}, rand_bits(32));
        end
        report_test();

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected reads never completed", exp_q.size());
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: dv/mem_model.sv
`timescale 1ns/100ps

module mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_req,
    input  logic        mem_wr,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    output logic [31:0] mem_rdata,
    output logic        mem_addr_ok,
    output logic        mem_data_ok,
    input  int          addr_delay,    // wait cycles before addr_ok
    input  int          data_delay,    // wait cycles between accept and data_ok
    output int          reads,
    output int          writes,
    output logic [31:0] last_rd_addr,
    output logic [31:0] last_wr_addr,
    output logic [31:0] last_wr_data
);

    logic [31:0] words [logic [29:0]];  // only words written back are kept
    int          phase;                 // 0 wait req, 1 addr_ok out, 2 data delay
    int          wait_cnt;
    logic        req_wr;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [31:0] rd_word;

    // untouched words read as a hash of their word address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h6d2b_79f5;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            phase        <= 0;
            wait_cnt     <= 0;
            mem_addr_ok  <= 1'b0;
            mem_data_ok  <= 1'b0;
            mem_rdata    <= '0;
            reads        <= 0;
            writes       <= 0;
            last_rd_addr <= '0;
            last_wr_addr <= '0;
            last_wr_data <= '0;
        end else begin
            case (phase)
                0: begin
                    mem_data_ok <= 1'b0;
                    if (mem_req) begin
                        if (wait_cnt >= addr_delay) begin
                            mem_addr_ok <= 1'b1;
                            wait_cnt    <= 0;
                            phase       <= 1;
                        end else begin
                            wait_cnt <= wait_cnt + 1;
                        end
                    end
                end
                1: begin
                    // cache takes the address on this edge
                    mem_addr_ok <= 1'b0;
                    req_wr      <= mem_wr;
                    req_addr    <= mem_addr;
                    req_wdata   <= mem_wdata;
                    phase       <= 2;
                end
                default: begin
                    if (wait_cnt >= data_delay) begin
                        mem_data_ok <= 1'b1;
                        wait_cnt    <= 0;
                        phase       <= 0;
                        if (req_wr) begin
                            words[req_addr[31:2]] = req_wdata;
                            writes       <= writes + 1;
                            last_wr_addr <= req_addr;
                            last_wr_data <= req_wdata;
                        end else begin
                            rd_word = words.exists(req_addr[31:2]) ? words[req_addr[31:2]]
                                                                   : fill_word(req_addr);
                            mem_rdata    <= rd_word;
                            reads        <= reads + 1;
                            last_rd_addr <= req_addr;
                        end
                    end else begin
                        wait_cnt <= wait_cnt + 1;
                    end
                end
            endcase
        end
    end

endmodule

// File: hdl/d_cache.sv
`timescale 1ns/100ps
`include "dcache_defs.svh"

module d_cache (
    input  logic                 clk,
    input  logic                 rst,

    // core side
    input  logic                 data_req,
    input  logic                 data_wr,
    input  dcache_pkg::dc_size_e data_size,
    input  logic [31:0]          data_addr,
    input  logic [31:0]          data_wdata,
    output logic [31:0]          data_rdata,
    output logic                 data_addr_ok,
    output logic                 data_data_ok,

    // memory side, always whole words
    output logic                 mem_req,
    output logic                 mem_wr,
    output logic [31:0]          mem_addr,
    output logic [31:0]          mem_wdata,
    input  logic [31:0]          mem_rdata,
    input  logic                 mem_addr_ok,
    input  logic                 mem_data_ok
);

    logic [`DC_OFFSET_WIDTH-1:0] offset;
    logic [`DC_INDEX_WIDTH-1:0]  index;
    logic [`DC_TAG_WIDTH-1:0]    tag;

    dcache_pkg::dc_state_e state;
    dcache_pkg::dc_state_e next_state;

    logic                     hit;
    dcache_pkg::way_t         hit_way;
    dcache_pkg::way_t         victim;
    dcache_pkg::way_t         way;       // way all line accesses go to
    logic                     line_dirty;
    logic [`DC_TAG_WIDTH-1:0] line_tag;
    logic [31:0]              line_data;

    logic idle_hit;    // request served this cycle
    logic in_wb;
    logic in_refill;
    logic addr_sent;   // memory took the address of the current transfer
    logic wb_done;
    logic refill_done;

    // the core holds the request, so no copy of the address is kept
    assign offset = data_addr[`DC_OFFSET_WIDTH-1:0];
    assign index  = data_addr[`DC_INDEX_WIDTH+`DC_OFFSET_WIDTH-1:`DC_OFFSET_WIDTH];
    assign tag    = data_addr[31:`DC_INDEX_WIDTH+`DC_OFFSET_WIDTH];

    // victim stays put during a miss since the tree only moves on hits
    assign way = hit ? hit_way : victim;

    cache_store u_store (
        .clk         (clk),
        .rst         (rst),
        .index       (index),
        .tag         (tag),
        .way         (way),
        .refill      (refill_done),
        .refill_data (mem_rdata),
        .store       (idle_hit && data_wr),
        .size        (data_size),
        .offset      (offset),
        .wdata       (data_wdata),
        .hit         (hit),
        .hit_way     (hit_way),
        .line_dirty  (line_dirty),
        .line_tag    (line_tag),
        .line_data   (line_data)
    );

    plru_tree u_plru (
        .clk      (clk),
        .rst      (rst),
        .index    (index),
        .touch    (idle_hit),
        .used_way (way),
        .victim   (victim)
    );

    assign in_wb     = (state == dcache_pkg::DC_WRITE_BACK);
    assign in_refill = (state == dcache_pkg::DC_REFILL);

    // a store after a refill waits for this, so it lands exactly once
    assign idle_hit = (state == dcache_pkg::DC_IDLE) && data_req && hit;

    assign wb_done     = in_wb && addr_sent && mem_data_ok;
    assign refill_done = in_refill && addr_sent && mem_data_ok;

    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::DC_IDLE: begin
                if (data_req && !hit) begin
                    // line_dirty belongs to the victim here
                    next_state = line_dirty ? dcache_pkg::DC_WRITE_BACK
                                            : dcache_pkg::DC_REFILL;
                end
            end
            dcache_pkg::DC_WRITE_BACK: begin
                if (wb_done) begin
                    next_state = dcache_pkg::DC_REFILL;
                end
            end
            dcache_pkg::DC_REFILL: begin
                if (refill_done) begin
                    next_state = dcache_pkg::DC_IDLE;  // held request hits next
                end
            end
            default: next_state = dcache_pkg::DC_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::DC_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // drop mem_req once the address is taken, rearm at end of transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            addr_sent <= 1'b0;
        end else if (wb_done || refill_done) begin
            addr_sent <= 1'b0;
        end else if (mem_req && mem_addr_ok) begin
            addr_sent <= 1'b1;
        end
    end

    assign mem_req   = (in_wb || in_refill) && !addr_sent;
    assign mem_wr    = in_wb;
    // writeback goes to the old line address
    assign mem_addr  = in_wb ? {line_tag, index, {`DC_OFFSET_WIDTH{1'b0}}}
                             : {tag, index, {`DC_OFFSET_WIDTH{1'b0}}};
    assign mem_wdata = line_data;

    // core only ever sees a hit, misses just stretch the wait
    assign data_addr_ok = idle_hit;
    assign data_data_ok = idle_hit;
    assign data_rdata   = line_data;

endmodule

// File: hdl/plru_tree.sv
`timescale 1ns/100ps
`include "dcache_defs.svh"

module plru_tree (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`DC_INDEX_WIDTH-1:0] index,
    input  logic                       touch,
    input  dcache_pkg::way_t           used_way,
    output dcache_pkg::way_t           victim
);

    // bit 2 is the root
    // bit 1 guards ways 0-1 and bit 0 guards ways 2-3
    logic [2:0] tree_mem [`DC_SETS];
    logic [2:0] tree;

    assign tree = tree_mem[index];

    // follow the root into the half it points at
    assign victim = tree[2] ? {tree[2], tree[0]} : {tree[2], tree[1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                tree_mem[s] <= 3'b000;
            end
        end else if (touch) begin
            // point the path away from the way just used
            if (!used_way[1]) begin
                {tree_mem[index][2], tree_mem[index][1]} <= ~used_way;
            end else begin
                {tree_mem[index][2], tree_mem[index][0]} <= ~used_way;
            end
        end
    end

endmodule

// File: hdl/cache_store.sv
`timescale 1ns/100ps
`include "dcache_defs.svh"

module cache_store (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`DC_INDEX_WIDTH-1:0]   index,
    input  logic [`DC_TAG_WIDTH-1:0]     tag,
    input  dcache_pkg::way_t             way,
    input  logic                         refill,
    input  logic [31:0]                  refill_data,
    input  logic                         store,
    input  dcache_pkg::dc_size_e         size,
    input  logic [`DC_OFFSET_WIDTH-1:0]  offset,
    input  logic [31:0]                  wdata,
    output logic                         hit,
    output dcache_pkg::way_t             hit_way,
    output logic                         line_dirty,
    output logic [`DC_TAG_WIDTH-1:0]     line_tag,
    output logic [31:0]                  line_data
);

    // per-set state bits, one per way
    logic [`DC_WAYS-1:0]      valid_mem [`DC_SETS];
    logic [`DC_WAYS-1:0]      dirty_mem [`DC_SETS];

    // payload arrays
    logic [`DC_TAG_WIDTH-1:0] tag_mem   [`DC_SETS][`DC_WAYS];
    logic [31:0]              data_mem  [`DC_SETS][`DC_WAYS];

    logic [`DC_WAYS-1:0] match;      // tag hit per way
    logic [3:0]          byte_mask;  // bytes touched by a store
    logic [31:0]         bit_mask;
    logic [31:0]         merged;     // old word with store bytes in place

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            match[w] = valid_mem[index][w] && (tag_mem[index][w] == tag);
        end
    end

    assign hit = |match;

    // lowest matching way wins, though only one should ever match
    always_comb begin
        hit_way = '0;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = dcache_pkg::way_t'(w);
            end
        end
    end

    // selected line, either the hit way or the victim
    assign line_dirty = dirty_mem[index][way];
    assign line_tag   = tag_mem[index][way];
    assign line_data  = data_mem[index][way];

    // byte lanes are already placed by the core, only the mask is needed
    always_comb begin
        case (size)
            dcache_pkg::SIZE_BYTE: byte_mask = 4'b0001 << offset;
            dcache_pkg::SIZE_HALF: byte_mask = offset[1] ? 4'b1100 : 4'b0011;
            default:               byte_mask = 4'b1111;
        endcase
    end

    assign bit_mask = {{8{byte_mask[3]}}, {8{byte_mask[2]}},
                       {8{byte_mask[1]}}, {8{byte_mask[0]}}};
    assign merged   = (line_data & ~bit_mask) | (wdata & bit_mask);

    // valid and dirty bits, all sets cleared in the reset cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
            end
        end else if (refill) begin
            valid_mem[index][way] <= 1'b1;
            dirty_mem[index][way] <= 1'b0;  // fresh from memory
        end else if (store) begin
            dirty_mem[index][way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill) begin
            tag_mem[index][way]  <= tag;
            data_mem[index][way] <= refill_data;
        end else if (store) begin
            data_mem[index][way] <= merged;
        end
    end

endmodule

// File: hdl/dcache_pkg.sv
package dcache_pkg;

    // miss handling states of the controller
    typedef enum logic [1:0] {
        DC_IDLE       = 2'd0,  // hits served here
        DC_WRITE_BACK = 2'd1,  // dirty victim going out
        DC_REFILL     = 2'd2   // new word coming in
    } dc_state_e;

    // core access size, same encoding as the core's size field
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } dc_size_e;

    // way number within a set
    typedef logic [1:0] way_t;

endpackage

// File: include/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// address split of a 32-bit byte address
// | tag | index | offset |
`define DC_OFFSET_WIDTH 2
`define DC_INDEX_WIDTH  10
`define DC_TAG_WIDTH    (32 - `DC_INDEX_WIDTH - `DC_OFFSET_WIDTH)

// array depth
`define DC_SETS (1 << `DC_INDEX_WIDTH)

// fixed at four by the 3-bit plru tree
`define DC_WAYS 4

`endif
